/* src/riscv_pkg.sv */
// --------------------------------------
// RV32I pipeline shared definitions
// Widths, opcodes, ALU codes and the
// instruction word views
// --------------------------------------
`default_nettype none

package riscv_pkg;

	// Data path and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_OP_W   = 4;

	// Byte step per fetched word
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;

	// ALU operation codes --------------------
	localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd7;

	// Supported major opcodes ----------------
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [6:0]            funct7;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} r_fmt;
		struct packed {
			logic [11:0]           imm_11_0;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [REG_ADDR_W-1:0] rd;
			logic [6:0]            opcode;
		} i_fmt;
		struct packed {
			logic [6:0]            imm_11_5;
			logic [REG_ADDR_W-1:0] rs2;
			logic [REG_ADDR_W-1:0] rs1;
			logic [2:0]            funct3;
			logic [4:0]            imm_4_0;
			logic [6:0]            opcode;
		} s_fmt;
	} instr_u;

endpackage

`default_nettype wire

/* src/pipe_if.sv */
// --------------------------------------
// Stage boundary bundles
// Decode to execute and execute to memory
// --------------------------------------
`default_nettype none

// Decode/execute register contents
interface id_ex_if;

	logic [riscv_pkg::REG_ADDR_W-1:0] rs1;
	logic [riscv_pkg::REG_ADDR_W-1:0] rs2;
	logic [riscv_pkg::REG_ADDR_W-1:0] rd;
	// Register values read in decode
	logic [riscv_pkg::XLEN-1:0]       op_a;
	logic [riscv_pkg::XLEN-1:0]       op_b_reg;
	logic [riscv_pkg::XLEN-1:0]       imm;
	logic                             use_imm;
	logic [riscv_pkg::ALU_OP_W-1:0]   alu_op;
	// Control flags
	logic                             reg_write;
	logic                             mem_read;
	logic                             mem_write;

	modport id_src (output rs1, rs2, rd, op_a, op_b_reg, imm, use_imm, alu_op,
		reg_write, mem_read, mem_write);
	modport ex_dst (input rs1, rs2, rd, op_a, op_b_reg, imm, use_imm, alu_op,
		reg_write, mem_read, mem_write);

endinterface

// Execute/memory register contents
interface ex_mem_if;

	// ALU result doubles as the APB address
	logic [riscv_pkg::XLEN-1:0]       alu_result;
	logic [riscv_pkg::XLEN-1:0]       store_data;
	logic [riscv_pkg::REG_ADDR_W-1:0] rd;
	logic                             reg_write;
	logic                             mem_read;
	logic                             mem_write;

	modport ex_src (output alu_result, store_data, rd, reg_write, mem_read, mem_write);
	modport mem_dst (input alu_result, store_data, rd, reg_write, mem_read, mem_write);

endinterface

`default_nettype wire

/* src/register_file.sv */
// --------------------------------------
// Integer register file
// x1..x31 writable and x0 reads zero
// --------------------------------------
`default_nettype none

module register_file (
	input  wire logic                             clk,
	input  wire logic                             rst_n_i,
	input  wire logic [riscv_pkg::REG_ADDR_W-1:0] rs1_i,
	input  wire logic [riscv_pkg::REG_ADDR_W-1:0] rs2_i,
	input  wire logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  wire logic [riscv_pkg::XLEN-1:0]       wb_data_i,
	input  wire logic                             wb_write_i,
	output logic [riscv_pkg::XLEN-1:0]            rs1_data_o,
	output logic [riscv_pkg::XLEN-1:0]            rs2_data_o
);

	logic [riscv_pkg::XLEN-1:0] regs [1:31];

	// Read port with write-through of the value being written
	function automatic logic [riscv_pkg::XLEN-1:0] read_port(
		input logic [riscv_pkg::REG_ADDR_W-1:0] addr
	);
		if (addr == '0)
			return '0;
		else if (wb_write_i && wb_rd_i == addr)
			return wb_data_i;
		else
			return regs[addr];
	endfunction

	always_comb begin
		rs1_data_o = read_port(rs1_i);
		rs2_data_o = read_port(rs2_i);
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_write_i && wb_rd_i != '0) begin
			regs[wb_rd_i] <= wb_data_i;
		end
	end

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// --------------------------------------
// Fetch stage
// PC and the fetch/decode register
// --------------------------------------
`default_nettype none

module fetch_stage (
	input  wire logic                       clk,
	input  wire logic                       rst_n_i,
	input  wire logic                       load_use_stall_i,
	input  wire logic                       mem_busy_i,
	input  wire logic [riscv_pkg::XLEN-1:0] instr_data_i,
	output logic [riscv_pkg::XLEN-1:0]      instr_addr_o,
	output logic [riscv_pkg::XLEN-1:0]      if_pc_o,
	output riscv_pkg::instr_u               if_instr_o
);

	logic                       hold;
	logic [riscv_pkg::XLEN-1:0] pc_q;

	// Either hazard freezes the front end
	assign hold         = load_use_stall_i | mem_busy_i;
	assign instr_addr_o = pc_q;

	// PC and fetched word
	// A zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q       <= '0;
			if_instr_o <= '0;
		end else if (!hold) begin
			pc_q       <= pc_q + riscv_pkg::PC_STEP;
			if_instr_o <= instr_data_i;
		end
	end

	// PC of the word now in decode
	always_ff @(posedge clk) begin
		if (!hold) begin
			if_pc_o <= pc_q;
		end
	end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
// --------------------------------------
// Decode stage
// Field decode, immediates, load-use
// detection and the decode/execute reg
// --------------------------------------
`default_nettype none

module decode_stage (
	input  wire logic                             clk,
	input  wire logic                             rst_n_i,
	input  wire logic                             mem_busy_i,
	input  wire riscv_pkg::instr_u                if_instr_i,
	input  wire logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  wire logic [riscv_pkg::XLEN-1:0]       wb_data_i,
	input  wire logic                             wb_write_i,
	output logic                                  load_use_stall_o,
	id_ex_if.id_src                               id_ex
);

	logic [riscv_pkg::XLEN-1:0]     rs1_data;
	logic [riscv_pkg::XLEN-1:0]     rs2_data;
	logic [riscv_pkg::XLEN-1:0]     i_imm;
	logic [riscv_pkg::XLEN-1:0]     s_imm;
	logic [riscv_pkg::ALU_OP_W-1:0] f3_op;
	logic [riscv_pkg::ALU_OP_W-1:0] alu_op;
	logic                           f3_known;
	logic                           valid;
	logic                           uses_rs2;
	logic                           use_imm;
	logic                           reg_write;
	logic                           mem_read;
	logic                           mem_write;

	register_file u_register_file (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rs1_i      (if_instr_i.r_fmt.rs1),
		.rs2_i      (if_instr_i.r_fmt.rs2),
		.wb_rd_i    (wb_rd_i),
		.wb_data_i  (wb_data_i),
		.wb_write_i (wb_write_i),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	// Sign extended immediates
	assign i_imm = {{(riscv_pkg::XLEN-12){if_instr_i.i_fmt.imm_11_0[11]}},
		if_instr_i.i_fmt.imm_11_0};
	assign s_imm = {{(riscv_pkg::XLEN-12){if_instr_i.s_fmt.imm_11_5[6]}},
		if_instr_i.s_fmt.imm_11_5, if_instr_i.s_fmt.imm_4_0};

	// funct3 to ALU code
	// No sltu or sra support
	always_comb begin
		f3_known = 1'b1;
		case (if_instr_i.r_fmt.funct3)
			3'b000:  f3_op = riscv_pkg::ALU_ADD;
			3'b001:  f3_op = riscv_pkg::ALU_SLL;
			3'b010:  f3_op = riscv_pkg::ALU_SLT;
			3'b100:  f3_op = riscv_pkg::ALU_XOR;
			3'b101:  f3_op = riscv_pkg::ALU_SRL;
			3'b110:  f3_op = riscv_pkg::ALU_OR;
			3'b111:  f3_op = riscv_pkg::ALU_AND;
			default: begin
				f3_op    = riscv_pkg::ALU_ADD;
				f3_known = 1'b0;
			end
		endcase
	end

	// Control decode
	// Anything unknown becomes a bubble
	always_comb begin
		valid     = 1'b0;
		uses_rs2  = 1'b0;
		use_imm   = 1'b1;
		alu_op    = riscv_pkg::ALU_ADD;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		case (if_instr_i.r_fmt.opcode)
			riscv_pkg::OPC_OP: begin
				valid     = f3_known;
				uses_rs2  = 1'b1;
				use_imm   = 1'b0;
				reg_write = f3_known;
				// funct7 bit 5 picks sub over add
				alu_op    = (if_instr_i.r_fmt.funct3 == 3'b000 && if_instr_i.r_fmt.funct7[5])
					? riscv_pkg::ALU_SUB : f3_op;
			end
			riscv_pkg::OPC_OP_IMM: begin
				valid     = f3_known;
				reg_write = f3_known;
				alu_op    = f3_op;
			end
			riscv_pkg::OPC_LOAD: begin
				valid     = (if_instr_i.i_fmt.funct3 == 3'b010);
				reg_write = valid;
				mem_read  = valid;
			end
			riscv_pkg::OPC_STORE: begin
				valid     = (if_instr_i.s_fmt.funct3 == 3'b010);
				uses_rs2  = 1'b1;
				mem_write = valid;
			end
			default: valid = 1'b0;
		endcase
	end

	// Load in execute feeding this instruction
	assign load_use_stall_o = id_ex.mem_read && (id_ex.rd != '0) && valid &&
		((if_instr_i.r_fmt.rs1 == id_ex.rd) || (uses_rs2 && if_instr_i.r_fmt.rs2 == id_ex.rd));

	// Decode/execute register --------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			id_ex.reg_write <= 1'b0;
			id_ex.mem_read  <= 1'b0;
			id_ex.mem_write <= 1'b0;
		end else if (!mem_busy_i) begin
			// Bubble on a load-use hazard
			id_ex.reg_write <= reg_write & ~load_use_stall_o;
			id_ex.mem_read  <= mem_read & ~load_use_stall_o;
			id_ex.mem_write <= mem_write & ~load_use_stall_o;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy_i) begin
			id_ex.rs1      <= if_instr_i.r_fmt.rs1;
			// Unused rs2 zeroed so it never forwards
			id_ex.rs2      <= uses_rs2 ? if_instr_i.r_fmt.rs2 : '0;
			id_ex.rd       <= mem_write ? '0 : if_instr_i.r_fmt.rd;
			id_ex.op_a     <= rs1_data;
			id_ex.op_b_reg <= rs2_data;
			id_ex.imm      <= mem_write ? s_imm : i_imm;
			id_ex.use_imm  <= use_imm;
			id_ex.alu_op   <= alu_op;
		end
	end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// --------------------------------------
// Execute stage
// Operand forwarding, ALU and the
// execute/memory register
// --------------------------------------
`default_nettype none

module execute_stage (
	input  wire logic                             clk,
	input  wire logic                             rst_n_i,
	input  wire logic                             mem_busy_i,
	id_ex_if.ex_dst                               id_ex,
	input  wire logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd_i,
	input  wire logic [riscv_pkg::XLEN-1:0]       wb_data_i,
	input  wire logic                             wb_write_i,
	ex_mem_if.ex_src                              ex_mem
);

	logic [riscv_pkg::XLEN-1:0] opa;
	logic [riscv_pkg::XLEN-1:0] opb_reg;
	logic [riscv_pkg::XLEN-1:0] opb;
	logic [riscv_pkg::XLEN-1:0] result;

	// Newest producer wins
	// Loads in memory never forward their address
	function automatic logic [riscv_pkg::XLEN-1:0] fwd_operand(
		input logic [riscv_pkg::REG_ADDR_W-1:0] src,
		input logic [riscv_pkg::XLEN-1:0]       reg_val
	);
		if (src != '0 && ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == src)
			return ex_mem.alu_result;
		else if (src != '0 && wb_write_i && wb_rd_i == src)
			return wb_data_i;
		else
			return reg_val;
	endfunction

	always_comb begin
		opa     = fwd_operand(id_ex.rs1, id_ex.op_a);
		opb_reg = fwd_operand(id_ex.rs2, id_ex.op_b_reg);
		opb     = id_ex.use_imm ? id_ex.imm : opb_reg;
	end

	// ALU -----------------------------------
	always_comb begin
		case (id_ex.alu_op)
			riscv_pkg::ALU_ADD: result = opa + opb;
			riscv_pkg::ALU_SUB: result = opa - opb;
			riscv_pkg::ALU_AND: result = opa & opb;
			riscv_pkg::ALU_OR:  result = opa | opb;
			riscv_pkg::ALU_XOR: result = opa ^ opb;
			riscv_pkg::ALU_SLT: result = {31'd0, $signed(opa) < $signed(opb)};
			riscv_pkg::ALU_SLL: result = opa << opb[4:0];
			riscv_pkg::ALU_SRL: result = opa >> opb[4:0];
			default:            result = opa + opb;
		endcase
	end

	// Execute/memory register --------------
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			ex_mem.reg_write <= 1'b0;
			ex_mem.mem_read  <= 1'b0;
			ex_mem.mem_write <= 1'b0;
		end else if (!mem_busy_i) begin
			ex_mem.reg_write <= id_ex.reg_write;
			ex_mem.mem_read  <= id_ex.mem_read;
			ex_mem.mem_write <= id_ex.mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy_i) begin
			ex_mem.alu_result <= result;
			ex_mem.store_data <= opb_reg;
			ex_mem.rd         <= id_ex.rd;
		end
	end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
// --------------------------------------
// Memory stage
// APB requester for lw/sw and the
// memory/write-back register
// --------------------------------------
`default_nettype none

module memory_stage (
	input  wire logic                       clk,
	input  wire logic                       rst_n_i,
	ex_mem_if.mem_dst                       ex_mem,
	output logic                            psel_o,
	output logic                            penable_o,
	output logic                            pwrite_o,
	output logic [riscv_pkg::XLEN-1:0]      paddr_o,
	output logic [riscv_pkg::XLEN-1:0]      pwdata_o,
	input  wire logic [riscv_pkg::XLEN-1:0] prdata_i,
	input  wire logic                       pready_i,
	output logic                            mem_busy_o,
	output logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [riscv_pkg::XLEN-1:0]      wb_data_o,
	output logic                            wb_write_o
);

	logic mem_req;
	logic xfer_done;

	assign mem_req    = ex_mem.mem_read | ex_mem.mem_write;
	// Access phase with pready ends the transfer
	assign xfer_done  = psel_o & penable_o & pready_i;
	assign mem_busy_o = mem_req & ~xfer_done;

	// psel/penable pair is the idle/setup/access state
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			psel_o    <= 1'b0;
			penable_o <= 1'b0;
			pwrite_o  <= 1'b0;
		end else if (!psel_o && mem_req) begin
			psel_o   <= 1'b1;
			pwrite_o <= ex_mem.mem_write;
		end else if (psel_o && !penable_o) begin
			penable_o <= 1'b1;
		end else if (xfer_done) begin
			psel_o    <= 1'b0;
			penable_o <= 1'b0;
			pwrite_o  <= 1'b0;
		end
	end

	// Address and data latched at setup
	// Held steady until completion
	always_ff @(posedge clk) begin
		if (!psel_o && mem_req) begin
			paddr_o  <= ex_mem.alu_result;
			pwdata_o <= ex_mem.store_data;
		end
	end

	// Memory/write-back register ----------
	// Held while busy so write-back forwarding stays valid
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_write_o <= 1'b0;
		end else if (!mem_busy_o) begin
			wb_write_o <= ex_mem.reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy_o) begin
			wb_rd_o   <= ex_mem.rd;
			wb_data_o <= ex_mem.mem_read ? prdata_i : ex_mem.alu_result;
		end
	end

endmodule

`default_nettype wire

/* src/riscv_pipeline.sv */
// --------------------------------------
// RV32I five-stage pipeline top
// Instruction port and APB requester
// --------------------------------------
`default_nettype none

module riscv_pipeline (
	input  wire logic                       clk,
	input  wire logic                       rst_n_i,
	output logic [riscv_pkg::XLEN-1:0]      instr_addr_o,
	input  wire logic [riscv_pkg::XLEN-1:0] instr_data_i,
	output logic                            psel_o,
	output logic                            penable_o,
	output logic                            pwrite_o,
	output logic [riscv_pkg::XLEN-1:0]      paddr_o,
	output logic [riscv_pkg::XLEN-1:0]      pwdata_o,
	input  wire logic [riscv_pkg::XLEN-1:0] prdata_i,
	input  wire logic                       pready_i
);

	// Stage to stage nets -------------------
	riscv_pkg::instr_u                if_instr;
	logic                             load_use_stall;
	logic                             mem_busy;
	logic [riscv_pkg::REG_ADDR_W-1:0] wb_rd;
	logic [riscv_pkg::XLEN-1:0]       wb_data;
	logic                             wb_write;

	id_ex_if  u_id_ex_if ();
	ex_mem_if u_ex_mem_if ();

	fetch_stage u_fetch_stage (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.load_use_stall_i (load_use_stall),
		.mem_busy_i       (mem_busy),
		.instr_data_i     (instr_data_i),
		.instr_addr_o     (instr_addr_o),
		// PC of the word in decode
		.if_pc_o          (),
		.if_instr_o       (if_instr)
	);

	decode_stage u_decode_stage (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.mem_busy_i       (mem_busy),
		.if_instr_i       (if_instr),
		.wb_rd_i          (wb_rd),
		.wb_data_i        (wb_data),
		.wb_write_i       (wb_write),
		.load_use_stall_o (load_use_stall),
		.id_ex            (u_id_ex_if.id_src)
	);

	execute_stage u_execute_stage (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.mem_busy_i (mem_busy),
		.id_ex      (u_id_ex_if.ex_dst),
		.wb_rd_i    (wb_rd),
		.wb_data_i  (wb_data),
		.wb_write_i (wb_write),
		.ex_mem     (u_ex_mem_if.ex_src)
	);

	memory_stage u_memory_stage (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.ex_mem     (u_ex_mem_if.mem_dst),
		.psel_o     (psel_o),
		.penable_o  (penable_o),
		.pwrite_o   (pwrite_o),
		.paddr_o    (paddr_o),
		.pwdata_o   (pwdata_o),
		.prdata_i   (prdata_i),
		.pready_i   (pready_i),
		.mem_busy_o (mem_busy),
		.wb_rd_o    (wb_rd),
		.wb_data_o  (wb_data),
		.wb_write_o (wb_write)
	);

endmodule

`default_nettype wire

/* verification/riscv_pipeline_checker.sv */
// --------------------------------------
// APB protocol checks for the pipeline
// Bound to the top level
// --------------------------------------
`default_nettype none

module riscv_pipeline_checker (
	input wire logic                       clk,
	input wire logic                       rst_n_i,
	input wire logic                       psel_o,
	input wire logic                       penable_o,
	input wire logic                       pwrite_o,
	input wire logic [riscv_pkg::XLEN-1:0] paddr_o,
	input wire logic [riscv_pkg::XLEN-1:0] pwdata_o,
	input wire logic                       pready_i
);

	// Access phase only after a setup cycle
	penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(penable_o) |-> $past(psel_o && !penable_o))
		else $error("penable rose without a setup cycle");

	// Request fields steady until pready ends the transfer
	request_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(psel_o && !(penable_o && pready_i)) |=>
		($stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o)))
		else $error("paddr, pwrite or pwdata changed before pready");

	// Bus idle while in reset
	idle_in_reset: assert property (@(posedge clk)
		!rst_n_i |=> (!psel_o && !penable_o))
		else $error("psel or penable high during reset");

endmodule

`default_nettype wire

/* verification/riscv_pipeline_tb.sv */
// --------------------------------------
// Pipeline testbench
// Directed programs, instruction memory
// and an APB completer with wait states
// --------------------------------------
`default_nettype none

module riscv_pipeline_tb;

	// Five programs under 40 words
	// Three wait states per transfer at worst
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic        clk;
	logic        rst_n_i;
	logic [31:0] instr_addr_o;
	logic [31:0] instr_data_i;
	logic        psel_o;
	logic        penable_o;
	logic        pwrite_o;
	logic [31:0] paddr_o;
	logic [31:0] pwdata_o;
	logic [31:0] prdata_i;
	logic        pready_i;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:63];
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [1:0]  waits_left;
	integer      seed;
	int          errors;
	int          cycles;
	int          pc_n;
	int          st_off;

	riscv_pipeline u_riscv_pipeline (.*);

	bind riscv_pipeline riscv_pipeline_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Instruction memory
	// Nops past the end
	assign instr_data_i = (instr_addr_o < 32'd256) ? imem[instr_addr_o[7:2]] : NOP;

	// APB completer ------------------------
	always @(posedge clk) begin
		if (!rst_n_i) begin
			pready_i <= 1'b0;
		end else if (psel_o && !penable_o) begin
			waits_left = $random(seed) & 3;
			pready_i <= (waits_left == 2'd0);
			prdata_i <= dmem[paddr_o[7:2]];
		end else if (psel_o && penable_o) begin
			if (pready_i) begin
				pready_i <= 1'b0;
				if (pwrite_o) begin
					dmem[paddr_o[7:2]] = pwdata_o;
					got_addr.push_back(paddr_o);
					got_data.push_back(pwdata_o);
				end
			end else begin
				waits_left = waits_left - 2'd1;
				pready_i <= (waits_left == 2'd0);
			end
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the DUT did not finish its programs within %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Instruction encoders -----------------
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		riscv_pkg::instr_u w;
		w.r_fmt.funct7 = f7;
		w.r_fmt.rs2    = rs2;
		w.r_fmt.rs1    = rs1;
		w.r_fmt.funct3 = f3;
		w.r_fmt.rd     = rd;
		w.r_fmt.opcode = riscv_pkg::OPC_OP;
		return w;
	endfunction

	function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		riscv_pkg::instr_u w;
		w.i_fmt.imm_11_0 = imm;
		w.i_fmt.rs1      = rs1;
		w.i_fmt.funct3   = f3;
		w.i_fmt.rd       = rd;
		w.i_fmt.opcode   = opc;
		return w;
	endfunction

	function automatic logic [31:0] s_type(input logic [4:0] rs2, input logic [11:0] imm);
		riscv_pkg::instr_u w;
		w.s_fmt.imm_11_5 = imm[11:5];
		w.s_fmt.rs2      = rs2;
		w.s_fmt.rs1      = 5'd0;
		w.s_fmt.funct3   = 3'b010;
		w.s_fmt.imm_4_0  = imm[4:0];
		w.s_fmt.opcode   = riscv_pkg::OPC_STORE;
		return w;
	endfunction

	// Program and expectation helpers ------
	task automatic emit(input logic [31:0] w);
		imem[pc_n] = w;
		pc_n++;
	endtask

	task automatic store_reg(input logic [4:0] rs2, input logic [11:0] off, input logic [31:0] d);
		emit(s_type(rs2, off));
		exp_addr.push_back({20'd0, off});
		exp_data.push_back(d);
	endtask

	// Op into x4, then store x4 at the next slot
	task automatic alu_case(input logic [31:0] w, input logic [31:0] d);
		emit(w);
		store_reg(5'd4, st_off[11:0], d);
		st_off += 4;
	endtask

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// Reset held while the next program is written
	task automatic hold_reset();
		@(posedge clk);
		rst_n_i <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < 64; i++) begin
			imem[i] = NOP;
		end
		got_addr.delete();
		got_data.delete();
		exp_addr.delete();
		exp_data.delete();
		pc_n   = 0;
		st_off = 0;
	endtask

	task automatic run_program(input string name);
		for (int i = 0; i < 15; i++) begin
			@(posedge clk);
			check({name, " psel in reset"}, {31'd0, psel_o}, 32'd0);
			check({name, " penable in reset"}, {31'd0, penable_o}, 32'd0);
		end
		rst_n_i <= 1'b1;
		while (got_addr.size() < exp_addr.size()) begin
			@(posedge clk);
		end
		foreach (exp_addr[i]) begin
			check({name, " store address"}, got_addr[i], exp_addr[i]);
			check({name, " store data"}, got_data[i], exp_data[i]);
		end
	endtask

	// Directed tests -----------------------
	task automatic alu_results();
		logic [31:0] a;
		logic [31:0] b;
		a = 32'd100;
		b = -32'sd7;
		hold_reset();
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd100));
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, -12'sd7));
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd3));
		alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), a + b);
		alu_case(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), a - b);
		alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd4), a & b);
		alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd4), a | b);
		alu_case(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd4), a ^ b);
		// Signed -7 is below 100
		alu_case(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd4), 32'd1);
		alu_case(r_type(7'h00, 5'd3, 5'd1, 3'b001, 5'd4), a << 3);
		alu_case(r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd4), b >> 3);
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd4, 5'd1, -12'sd50), a - 32'd50);
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b111, 5'd4, 5'd2, 12'h0F0), b & 32'h0F0);
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b110, 5'd4, 5'd1, 12'hF00), a | 32'hFFFF_FF00);
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b100, 5'd4, 5'd2, 12'h555), b ^ 32'h555);
		// Signed 100 is not below -5
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b010, 5'd4, 5'd1, -12'sd5), 32'd0);
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b001, 5'd4, 5'd1, 12'd5), a << 5);
		alu_case(i_type(riscv_pkg::OPC_OP_IMM, 3'b101, 5'd4, 5'd2, 12'd28), b >> 28);
		run_program("alu");
	endtask

	// Dependent chain with no gaps
	task automatic forwarding_chain();
		logic [31:0] x6;
		logic [31:0] x7;
		logic [31:0] x8;
		logic [31:0] x9;
		x6 = 32'd7 + 32'd7;
		x7 = x6 ^ 32'd7;
		x8 = x7 & x6;
		x9 = x8 | 32'd7;
		hold_reset();
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd5, 5'd0, 12'd7));
		emit(r_type(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));
		emit(r_type(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));
		emit(r_type(7'h00, 5'd6, 5'd7, 3'b111, 5'd8));
		emit(r_type(7'h00, 5'd5, 5'd8, 3'b110, 5'd9));
		emit(r_type(7'h20, 5'd6, 5'd9, 3'b000, 5'd10));
		store_reg(5'd10, 12'h000, x9 - x6);
		store_reg(5'd9, 12'h004, x9);
		store_reg(5'd6, 12'h008, x6);
		run_program("forwarding");
	endtask

	task automatic load_use_bubble();
		hold_reset();
		dmem[16] = $random(seed);
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd13, 5'd0, 12'd25));
		emit(i_type(riscv_pkg::OPC_LOAD, 3'b010, 5'd11, 5'd0, 12'h040));
		emit(r_type(7'h00, 5'd11, 5'd13, 3'b000, 5'd12));
		store_reg(5'd12, 12'h000, dmem[16] + 32'd25);
		run_program("load-use");
	endtask

	// Loads and stores under random wait states
	task automatic wait_state_traffic();
		logic [31:0] a;
		logic [31:0] b;
		hold_reset();
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'h9E37_79B9 * (i + 1);
		end
		a = dmem[32];
		b = dmem[33];
		emit(i_type(riscv_pkg::OPC_LOAD, 3'b010, 5'd1, 5'd0, 12'h080));
		emit(i_type(riscv_pkg::OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h084));
		store_reg(5'd1, 12'h010, a);
		emit(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		store_reg(5'd3, 12'h014, a + b);
		store_reg(5'd2, 12'h018, b);
		emit(i_type(riscv_pkg::OPC_LOAD, 3'b010, 5'd4, 5'd0, 12'h010));
		store_reg(5'd4, 12'h01C, a);
		run_program("back-pressure");
	endtask

	task automatic x0_writes();
		hold_reset();
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd55));
		emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd9));
		emit(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
		store_reg(5'd0, 12'h000, 32'd0);
		emit(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd5));
		store_reg(5'd5, 12'h004, 32'd9);
		run_program("x0");
	endtask

	initial begin
		seed     = 43;
		errors   = 0;
		cycles   = 0;
		rst_n_i  = 1'b0;
		prdata_i = '0;
		pready_i = 1'b0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = NOP;
			dmem[i] = 32'hA5A5_0000 + i;
		end
		alu_results();
		forwarding_chain();
		load_use_bubble();
		wait_state_traffic();
		x0_writes();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/riscv_pkg.sv
src/pipe_if.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/riscv_pipeline.sv
verification/riscv_pipeline_checker.sv
verification/riscv_pipeline_tb.sv

/* Bender.yml */
package:
  name: riscv_pipeline

sources:
  - src/riscv_pkg.sv
  - src/pipe_if.sv
  - src/register_file.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_stage.sv
  - src/riscv_pipeline.sv
  - target: test
    files:
      - verification/riscv_pipeline_checker.sv
      - verification/riscv_pipeline_tb.sv
